/* qspim.f */
hw/qspim_pkg.sv
hw/qspim_cmd_cfg_if.sv
hw/qspim_cs_decode.sv
hw/qspim_mem_rd_fsm.sv
hw/qspim_wb_resp.sv
hw/qspim_if.sv
+incdir+testbench
testbench/tb_qspim_if.sv

/* testbench/tb_qspim_model.svh */
// ------------------------------
// External FIFO, SPI engine and register file models
// ------------------------------
logic [31:0] rng_state = 32'd67;
cmd_word_t   cmd_q[$];            // Captured command words
int          cmd_delay = -1;      // Cycles until drained or -1 when empty
logic        cmd_hold = 1'b0;     // Engine stall keeps the FIFO non-empty
logic        cmd_busy = 1'b0;     // Forced not empty
burst_len_t  bl_cur;              // Words the engine returns
int          gen_left = 0;
wb_data_t    res_q[$];            // Response FIFO contents
wb_data_t    beat_q[$];           // Popped words awaiting their ack
logic        bry_rand = 1'b0;
wb_data_t    regs [16];           // Register file
int          reg_wait = 0;
int          reg_target = 0;
logic        ack_seen;
logic        lack_seen;
wb_data_t    dat_seen;
byte_en_t    be_seen;             // Byte enables towards the register file

function logic [31:0] xorshift32();
  rng_state = rng_state ^ (rng_state << 13);
  rng_state = rng_state ^ (rng_state >> 17);
  rng_state = rng_state ^ (rng_state << 5);
  return rng_state;
endfunction

// Called at the falling edge while outputs are settled
task sample_outputs();
  ack_seen  = wbd_ack_o;
  lack_seen = wbd_lack_o;
  dat_seen  = wbd_dat_o;
  be_seen   = spim_reg_be_o;
  if (cmd_fifo_wr_o) begin
    cmd_q.push_back(cmd_fifo_wdata_o);
    cmd_delay = cmd_fifo_wdata_o[48] ? 1 + int'(xorshift32() % 6) : 1000;  // EOC drains
  end
  if (res_fifo_rd_o) begin
    if (res_q.size() == 0) fail_run("response FIFO read while it was empty");
    else beat_q.push_back(res_q.pop_front());
  end
  if (spim_reg_req_o && spim_reg_ack_i) begin
    if (spim_reg_we_o) regs[spim_reg_addr_o] = spim_reg_wdata_o;
    reg_wait   = 0;
    reg_target = int'(xorshift32() % 4);  // Next ack latency
  end else if (spim_reg_req_o) begin
    reg_wait++;
  end
endtask

// Called just after the rising edge
task drive_models();
  if (cmd_delay > 0 && !cmd_hold) begin
    cmd_delay--;
    if (cmd_delay == 0) begin  // Engine returns data once the command is done
      cmd_delay = -1;
      gen_left  = bl_cur;
    end
  end
  if (gen_left > 0 && (xorshift32() % 2 == 1)) begin
    res_q.push_back(xorshift32());
    gen_left--;
  end
  cmd_fifo_empty_i = (cmd_delay < 0) && !cmd_busy;
  res_fifo_empty_i = (res_q.size() == 0);
  res_fifo_rdata_i = (res_q.size() != 0) ? res_q[0] : '0;
  wbd_bry_i        = bry_rand ? (xorshift32() % 4 != 0) : 1'b1;
  spim_reg_ack_i   = (reg_wait > reg_target);
  spim_reg_rdata_i = regs[spim_reg_addr_o];
endtask

/* testbench/tb_qspim_if.sv */
`default_nettype none

module tb_qspim_if;
  import qspim_pkg::*;

  localparam int TMO = 400;  // Cycles per wait

  logic mclk = 1'b0;
  logic rst_n;
  logic wbd_stb_i, wbd_we_i, wbd_bry_i, wbd_ack_o, wbd_lack_o;
  wb_data_t wbd_adr_i, wbd_dat_i, wbd_dat_o;
  byte_en_t wbd_sel_i;
  burst_len_t wbd_bl_i;
  cs_field_t cs_addr [4];
  cs_field_t cs_mask [4];
  logic cfg_fsm_reset_i, spi_init_done_i;
  spi_mode_t g_imode [2];
  spi_mode_t g_fmode [2];
  spi_mode_t g_switch [2];
  spi_seq_t g_seq [2];
  addr_cnt_t g_acnt [2];
  dummy_cnt_t g_dummy [2];
  spi_byte_t g_cmd [2];
  spi_byte_t g_mode [2];
  logic spim_reg_req_o, spim_reg_we_o, spim_reg_ack_i;
  reg_addr_t spim_reg_addr_o;
  byte_en_t spim_reg_be_o;
  wb_data_t spim_reg_wdata_o, spim_reg_rdata_i;
  logic cmd_fifo_empty_i, cmd_fifo_wr_o;
  cmd_word_t cmd_fifo_wdata_o;
  logic res_fifo_empty_i, res_fifo_rd_o;
  wb_data_t res_fifo_rdata_i;
  wb_data_t exp_regs [16];  // Last written value per index

  `include "tb_qspim_model.svh"

  always #50 mclk = ~mclk;

  qspim_if dut_i (
    .mclk(mclk), .rst_n(rst_n),
    .wbd_stb_i(wbd_stb_i), .wbd_we_i(wbd_we_i), .wbd_bry_i(wbd_bry_i),
    .wbd_adr_i(wbd_adr_i), .wbd_dat_i(wbd_dat_i), .wbd_sel_i(wbd_sel_i),
    .wbd_bl_i(wbd_bl_i), .wbd_dat_o(wbd_dat_o), .wbd_ack_o(wbd_ack_o),
    .wbd_lack_o(wbd_lack_o),
    .cfg_cs0_addr_i(cs_addr[0]), .cfg_cs1_addr_i(cs_addr[1]),
    .cfg_cs2_addr_i(cs_addr[2]), .cfg_cs3_addr_i(cs_addr[3]),
    .cfg_cs0_amask_i(cs_mask[0]), .cfg_cs1_amask_i(cs_mask[1]),
    .cfg_cs2_amask_i(cs_mask[2]), .cfg_cs3_amask_i(cs_mask[3]),
    .cfg_fsm_reset_i(cfg_fsm_reset_i), .spi_init_done_i(spi_init_done_i),
    .cfg_g0_imode_i(g_imode[0]), .cfg_g0_fmode_i(g_fmode[0]),
    .cfg_g0_switch_i(g_switch[0]), .cfg_g0_seq_i(g_seq[0]),
    .cfg_g0_addr_cnt_i(g_acnt[0]), .cfg_g0_dummy_cnt_i(g_dummy[0]),
    .cfg_g0_cmd_i(g_cmd[0]), .cfg_g0_mode_i(g_mode[0]),
    .cfg_g1_imode_i(g_imode[1]), .cfg_g1_fmode_i(g_fmode[1]),
    .cfg_g1_switch_i(g_switch[1]), .cfg_g1_seq_i(g_seq[1]),
    .cfg_g1_addr_cnt_i(g_acnt[1]), .cfg_g1_dummy_cnt_i(g_dummy[1]),
    .cfg_g1_cmd_i(g_cmd[1]), .cfg_g1_mode_i(g_mode[1]),
    .spim_reg_req_o(spim_reg_req_o), .spim_reg_we_o(spim_reg_we_o),
    .spim_reg_addr_o(spim_reg_addr_o), .spim_reg_be_o(spim_reg_be_o),
    .spim_reg_wdata_o(spim_reg_wdata_o), .spim_reg_ack_i(spim_reg_ack_i),
    .spim_reg_rdata_i(spim_reg_rdata_i),
    .cmd_fifo_empty_i(cmd_fifo_empty_i), .cmd_fifo_wr_o(cmd_fifo_wr_o),
    .cmd_fifo_wdata_o(cmd_fifo_wdata_o),
    .res_fifo_empty_i(res_fifo_empty_i), .res_fifo_rd_o(res_fifo_rd_o),
    .res_fifo_rdata_i(res_fifo_rdata_i)
  );

  // ------------------------------
  // Checks
  // ------------------------------
  task fail_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task check_data(input string name, input wb_data_t got, input wb_data_t exp);
    if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task check_cmd(input string name, input cmd_word_t got, input cmd_word_t exp);
    if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task check_be(input string name, input byte_en_t got, input byte_en_t exp);
    if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  task check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) fail_run($sformatf("error %s got %h expected %h", name, got, exp));
  endtask

  // One clock with inputs driven 1 unit after the edge
  task cycle();
    @(negedge mclk);
    sample_outputs();
    @(posedge mclk);
    #1;
    drive_models();
  endtask

  // Header layout from the command word definition
  function automatic cmd_word_t expect_header(input int k, input burst_len_t bl);
    int g;
    logic [11:0] bytes;
    g     = (k >= 2) ? 1 : 0;  // CS2 and CS3 use group 1
    bytes = 12'(bl) * 12'd4;
    return {1'b1, 1'b0, bytes, g_dummy[g], g_acnt[g], g_switch[g], g_fmode[g],
            g_imode[g], g_seq[g], 4'(1 << k), g_mode[g], g_cmd[g]};
  endfunction

  task wait_cmd_words();
    int t;
    t = 0;
    while (cmd_q.size() < 2) begin
      if (t > TMO) fail_run("timeout waiting for the command words");
      cycle();
      t++;
    end
  endtask

  task idle_no_ack();
    wbd_stb_i = 1'b0;
    repeat (2) begin
      cycle();
      check_bit("wbd_ack_o", ack_seen, 1'b0);
    end
  endtask

  task reg_access(input logic we, input reg_addr_t idx);
    int t;
    t         = 0;
    wbd_stb_i = 1'b1;
    wbd_we_i  = we;
    wbd_adr_i = 32'h1000_0000 | (32'(idx) << 2);  // Register region
    wbd_dat_i = xorshift32();
    wbd_sel_i = 4'(xorshift32());
    if (we) exp_regs[idx] = wbd_dat_i;
    do begin
      if (t > TMO) fail_run("timeout waiting for a register acknowledge");
      cycle();
      t++;
    end while (!ack_seen);
    check_bit("wbd_lack_o", lack_seen, 1'b1);
    check_be("spim_reg_be_o", be_seen, wbd_sel_i);
    if (we) check_data("wbd_dat_o", dat_seen, '0);
    else check_data("wbd_dat_o", dat_seen, exp_regs[idx]);
    idle_no_ack();
  endtask

  // mode 0 plain, 1 early-command gating, 2 FSM reset in cmd_wait
  task mem_read(input int k, input burst_len_t bl, input int mode);
    wb_data_t r;
    wb_data_t adr;
    int t;
    int beats;
    r   = xorshift32();
    adr = {r[31:29], 1'b0, 4'(k), r[23:2], 2'b00};
    bl_cur = bl;
    cmd_q.delete();
    if (mode == 1) spi_init_done_i = 1'b0;
    if (mode == 2) cmd_hold = 1'b1;
    wbd_stb_i = 1'b1;
    wbd_we_i  = 1'b0;
    wbd_adr_i = adr;
    wbd_dat_i = '0;
    wbd_bl_i  = bl;
    if (mode == 1) begin
      repeat (6) cycle();
      check_bit("cmd_fifo_wr_o", cmd_q.size() != 0, 1'b0);
      spi_init_done_i  = 1'b1;
      cmd_busy         = 1'b1;
      cmd_fifo_empty_i = 1'b0;
      repeat (6) cycle();
      check_bit("cmd_fifo_wr_o", cmd_q.size() != 0, 1'b0);
      cmd_busy = 1'b0;
    end
    wait_cmd_words();
    if (mode == 2) begin
      repeat (2) cycle();
      cfg_fsm_reset_i = 1'b1;
      cycle();
      cfg_fsm_reset_i = 1'b0;
      cmd_q.delete();
      cmd_hold  = 1'b0;
      cmd_delay = -1;  // Engine flushed and the FIFO empty again
      wait_cmd_words();
    end
    check_cmd("cmd_fifo_wdata_o", cmd_q[0], expect_header(k, bl));
    check_cmd("cmd_fifo_wdata_o", cmd_q[1], {1'b0, 1'b1, 16'h0, adr});
    t     = 0;
    beats = 0;
    while (!lack_seen) begin
      if (t > TMO) fail_run("timeout waiting for the last acknowledge of a burst");
      cycle();
      t++;
      if (ack_seen) begin
        if (beat_q.size() == 0) fail_run("acknowledge without a popped response word");
        beats++;
        check_data("wbd_dat_o", dat_seen, beat_q.pop_front());
        check_bit("wbd_lack_o", lack_seen, beats == int'(bl));
      end
    end
    idle_no_ack();
    check_bit("cmd_fifo_wr_o", cmd_q.size() != 2, 1'b0);  // No extra command
  endtask

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    rst_n = 1'b0;
    wbd_stb_i = 1'b0;
    wbd_we_i = 1'b0;
    wbd_bry_i = 1'b1;
    wbd_adr_i = '0;
    wbd_dat_i = '0;
    wbd_sel_i = '0;
    wbd_bl_i = '0;
    cfg_fsm_reset_i = 1'b0;
    spi_init_done_i = 1'b1;
    spim_reg_ack_i = 1'b0;
    spim_reg_rdata_i = '0;
    cmd_fifo_empty_i = 1'b1;
    res_fifo_empty_i = 1'b1;
    res_fifo_rdata_i = '0;
    for (int i = 0; i < 4; i++) begin
      cs_addr[i] = 8'(i << 4);  // Top nibble picks the chip select
      cs_mask[i] = 8'hf0;
    end
    for (int g = 0; g < 2; g++) begin
      g_imode[g] = 2'(xorshift32());
      g_fmode[g] = 2'(xorshift32());
      g_switch[g] = 2'(xorshift32());
      g_seq[g] = 4'(xorshift32());
      g_acnt[g] = 2'(xorshift32());
      g_dummy[g] = 4'(xorshift32());
      g_cmd[g] = 8'(xorshift32());
      g_mode[g] = 8'(xorshift32());
    end
    for (int i = 0; i < 16; i++) begin
      regs[i]     = '0;
      exp_regs[i] = '0;
    end
    repeat (5) @(posedge mclk);
    #1 rst_n = 1'b1;
    cycle();
    check_bit("wbd_ack_o", ack_seen, 1'b0);
    check_bit("wbd_lack_o", lack_seen, 1'b0);
    check_data("wbd_dat_o", dat_seen, '0);
    check_bit("cmd_fifo_wr_o", cmd_fifo_wr_o, 1'b0);
    check_bit("res_fifo_rd_o", res_fifo_rd_o, 1'b0);
    check_bit("spim_reg_req_o", spim_reg_req_o, 1'b0);
    repeat (20) reg_access(1'b1, 4'(xorshift32()));
    repeat (20) reg_access(1'b0, 4'(xorshift32()));
    bry_rand = 1'b1;  // Stalls from here on
    for (int i = 0; i < 8; i++) mem_read(i % 4, 10'(1 + xorshift32() % 8), 0);
    mem_read(int'(xorshift32() % 4), 10'(1 + xorshift32() % 8), 1);
    mem_read(int'(xorshift32() % 4), 10'(1 + xorshift32() % 8), 2);
    mem_read(3, 10'(1 + xorshift32() % 8), 0);
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/qspim_if.sv */
`default_nettype none

module qspim_if (
  input  logic                  mclk,
  input  logic                  rst_n,
  // ------------------------------
  // Wishbone side
  // ------------------------------
  input  logic                  wbd_stb_i,
  input  logic                  wbd_we_i,
  input  logic                  wbd_bry_i,           // Burst ready
  input  qspim_pkg::wb_data_t   wbd_adr_i,
  input  qspim_pkg::wb_data_t   wbd_dat_i,
  input  qspim_pkg::byte_en_t   wbd_sel_i,
  input  qspim_pkg::burst_len_t wbd_bl_i,
  output qspim_pkg::wb_data_t   wbd_dat_o,
  output logic                  wbd_ack_o,
  output logic                  wbd_lack_o,          // Last beat
  // Chip select map
  input  qspim_pkg::cs_field_t  cfg_cs0_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs1_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs2_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs3_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs0_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs1_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs2_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs3_amask_i,
  input  logic                  cfg_fsm_reset_i,
  input  logic                  spi_init_done_i,
  // Setting group 0
  input  qspim_pkg::spi_mode_t  cfg_g0_imode_i,
  input  qspim_pkg::spi_mode_t  cfg_g0_fmode_i,
  input  qspim_pkg::spi_mode_t  cfg_g0_switch_i,
  input  qspim_pkg::spi_seq_t   cfg_g0_seq_i,
  input  qspim_pkg::addr_cnt_t  cfg_g0_addr_cnt_i,
  input  qspim_pkg::dummy_cnt_t cfg_g0_dummy_cnt_i,
  input  qspim_pkg::spi_byte_t  cfg_g0_cmd_i,
  input  qspim_pkg::spi_byte_t  cfg_g0_mode_i,
  // Setting group 1
  input  qspim_pkg::spi_mode_t  cfg_g1_imode_i,
  input  qspim_pkg::spi_mode_t  cfg_g1_fmode_i,
  input  qspim_pkg::spi_mode_t  cfg_g1_switch_i,
  input  qspim_pkg::spi_seq_t   cfg_g1_seq_i,
  input  qspim_pkg::addr_cnt_t  cfg_g1_addr_cnt_i,
  input  qspim_pkg::dummy_cnt_t cfg_g1_dummy_cnt_i,
  input  qspim_pkg::spi_byte_t  cfg_g1_cmd_i,
  input  qspim_pkg::spi_byte_t  cfg_g1_mode_i,
  // ------------------------------
  // Register file side
  // ------------------------------
  output logic                  spim_reg_req_o,
  output logic                  spim_reg_we_o,
  output qspim_pkg::reg_addr_t  spim_reg_addr_o,
  output qspim_pkg::byte_en_t   spim_reg_be_o,
  output qspim_pkg::wb_data_t   spim_reg_wdata_o,
  input  logic                  spim_reg_ack_i,
  input  qspim_pkg::wb_data_t   spim_reg_rdata_i,
  // Command FIFO
  input  logic                  cmd_fifo_empty_i,
  output logic                  cmd_fifo_wr_o,
  output qspim_pkg::cmd_word_t  cmd_fifo_wdata_o,
  // Response FIFO
  input  logic                  res_fifo_empty_i,
  output logic                  res_fifo_rd_o,
  input  qspim_pkg::wb_data_t   res_fifo_rdata_i
);
  import qspim_pkg::*;

  logic     mem_req;    // Open memory-region strobe
  logic     mem_ack;    // Response beat popped
  logic     mem_last;
  wb_data_t mem_rdata;

  qspim_cmd_cfg_if cmd_cfg ();  // Settings for the hit chip select

  qspim_cs_decode u_cs_decode (
    .adr_i              (wbd_adr_i),
    .cfg_cs0_addr_i     (cfg_cs0_addr_i),
    .cfg_cs1_addr_i     (cfg_cs1_addr_i),
    .cfg_cs2_addr_i     (cfg_cs2_addr_i),
    .cfg_cs3_addr_i     (cfg_cs3_addr_i),
    .cfg_cs0_amask_i    (cfg_cs0_amask_i),
    .cfg_cs1_amask_i    (cfg_cs1_amask_i),
    .cfg_cs2_amask_i    (cfg_cs2_amask_i),
    .cfg_cs3_amask_i    (cfg_cs3_amask_i),
    .cfg_g0_imode_i     (cfg_g0_imode_i),
    .cfg_g0_fmode_i     (cfg_g0_fmode_i),
    .cfg_g0_switch_i    (cfg_g0_switch_i),
    .cfg_g0_seq_i       (cfg_g0_seq_i),
    .cfg_g0_addr_cnt_i  (cfg_g0_addr_cnt_i),
    .cfg_g0_dummy_cnt_i (cfg_g0_dummy_cnt_i),
    .cfg_g0_cmd_i       (cfg_g0_cmd_i),
    .cfg_g0_mode_i      (cfg_g0_mode_i),
    .cfg_g1_imode_i     (cfg_g1_imode_i),
    .cfg_g1_fmode_i     (cfg_g1_fmode_i),
    .cfg_g1_switch_i    (cfg_g1_switch_i),
    .cfg_g1_seq_i       (cfg_g1_seq_i),
    .cfg_g1_addr_cnt_i  (cfg_g1_addr_cnt_i),
    .cfg_g1_dummy_cnt_i (cfg_g1_dummy_cnt_i),
    .cfg_g1_cmd_i       (cfg_g1_cmd_i),
    .cfg_g1_mode_i      (cfg_g1_mode_i),
    .cfg_o              (cmd_cfg.src)
  );

  qspim_mem_rd_fsm u_mem_rd_fsm (
    .mclk             (mclk),
    .rst_n            (rst_n),
    .mem_req_i        (mem_req),
    .adr_i            (wbd_adr_i),
    .bl_i             (wbd_bl_i),
    .bry_i            (wbd_bry_i),
    .spi_init_done_i  (spi_init_done_i),
    .cfg_fsm_reset_i  (cfg_fsm_reset_i),
    .cfg_i            (cmd_cfg.dst),
    .cmd_fifo_empty_i (cmd_fifo_empty_i),
    .cmd_fifo_wr_o    (cmd_fifo_wr_o),
    .cmd_fifo_wdata_o (cmd_fifo_wdata_o),
    .res_fifo_empty_i (res_fifo_empty_i),
    .res_fifo_rd_o    (res_fifo_rd_o),
    .res_fifo_rdata_i (res_fifo_rdata_i),
    .mem_ack_o        (mem_ack),
    .mem_last_o       (mem_last),
    .mem_rdata_o      (mem_rdata)
  );

  qspim_wb_resp u_wb_resp (
    .mclk        (mclk),
    .rst_n       (rst_n),
    .stb_i       (wbd_stb_i),
    .we_i        (wbd_we_i),
    .adr_i       (wbd_adr_i),
    .dat_i       (wbd_dat_i),
    .sel_i       (wbd_sel_i),
    .mem_req_o   (mem_req),
    .mem_ack_i   (mem_ack),
    .mem_last_i  (mem_last),
    .mem_rdata_i (mem_rdata),
    .reg_req_o   (spim_reg_req_o),
    .reg_we_o    (spim_reg_we_o),
    .reg_addr_o  (spim_reg_addr_o),
    .reg_be_o    (spim_reg_be_o),
    .reg_wdata_o (spim_reg_wdata_o),
    .reg_ack_i   (spim_reg_ack_i),
    .reg_rdata_i (spim_reg_rdata_i),
    .ack_o       (wbd_ack_o),
    .lack_o      (wbd_lack_o),
    .dat_o       (wbd_dat_o)
  );

endmodule

`default_nettype wire

/* hw/qspim_wb_resp.sv */
`default_nettype none

module qspim_wb_resp (
  input  logic                 mclk,
  input  logic                 rst_n,
  input  logic                 stb_i,
  input  logic                 we_i,
  input  qspim_pkg::wb_data_t  adr_i,
  input  qspim_pkg::wb_data_t  dat_i,
  input  qspim_pkg::byte_en_t  sel_i,
  output logic                 mem_req_o,    // To the sequencer
  input  logic                 mem_ack_i,
  input  logic                 mem_last_i,
  input  qspim_pkg::wb_data_t  mem_rdata_i,
  output logic                 reg_req_o,    // Level, held until ack
  output logic                 reg_we_o,
  output qspim_pkg::reg_addr_t reg_addr_o,
  output qspim_pkg::byte_en_t  reg_be_o,
  output qspim_pkg::wb_data_t  reg_wdata_o,
  input  logic                 reg_ack_i,
  input  qspim_pkg::wb_data_t  reg_rdata_i,
  output logic                 ack_o,
  output logic                 lack_o,
  output qspim_pkg::wb_data_t  dat_o
);
  import qspim_pkg::*;

  logic open_stb;  // Strobe not yet closed by a last ack
  logic mem_hit;
  logic reg_hit;

  // ------------------------------
  // Region decode on bit 28
  // ------------------------------
  assign open_stb  = stb_i && !lack_o;
  assign mem_req_o = open_stb && !adr_i[REGION_BIT];
  assign reg_req_o = open_stb && adr_i[REGION_BIT];

  assign reg_we_o    = we_i;
  assign reg_addr_o  = adr_i[REG_IDX_MSB:REG_IDX_LSB];  // Word index
  assign reg_be_o    = sel_i;
  assign reg_wdata_o = dat_i;

  assign mem_hit = mem_req_o && mem_ack_i;
  assign reg_hit = reg_req_o && reg_ack_i;

  always_ff @(posedge mclk) begin
    if (!rst_n) begin
      ack_o  <= 1'b0;
      lack_o <= 1'b0;
      dat_o  <= '0;
    end else begin
      ack_o  <= mem_hit || reg_hit;
      lack_o <= (mem_hit && mem_last_i) || reg_hit;  // Register access is one beat
      if (!we_i && mem_hit) begin
        dat_o <= mem_rdata_i;
      end else if (!we_i && reg_hit) begin
        dat_o <= reg_rdata_i;
      end else begin
        dat_o <= '0;  // Writes and idle cycles
      end
    end
  end

  // Flash region is read only
  a_no_mem_wr: assert property (@(posedge mclk) disable iff (!rst_n)
    mem_req_o |-> !we_i);

endmodule

`default_nettype wire

/* hw/qspim_mem_rd_fsm.sv */
`default_nettype none

module qspim_mem_rd_fsm (
  input  logic                  mclk,
  input  logic                  rst_n,
  input  logic                  mem_req_i,         // Memory region strobe
  input  qspim_pkg::wb_data_t   adr_i,
  input  qspim_pkg::burst_len_t bl_i,              // Words
  input  logic                  bry_i,             // Master ready for a beat
  input  logic                  spi_init_done_i,
  input  logic                  cfg_fsm_reset_i,
  qspim_cmd_cfg_if.dst          cfg_i,
  input  logic                  cmd_fifo_empty_i,
  output logic                  cmd_fifo_wr_o,     // One-cycle pulse
  output qspim_pkg::cmd_word_t  cmd_fifo_wdata_o,
  input  logic                  res_fifo_empty_i,
  output logic                  res_fifo_rd_o,     // Data valid same cycle
  input  qspim_pkg::wb_data_t   res_fifo_rdata_i,
  output logic                  mem_ack_o,
  output logic                  mem_last_o,
  output qspim_pkg::wb_data_t   mem_rdata_o
);
  import qspim_pkg::*;

  mem_rd_state_e        state_q;
  mem_rd_state_e        state_d;
  burst_len_t           bl_cnt_q;  // Beats still to come
  burst_len_t           bl_cnt_d;
  wb_data_t             addr_q;    // Start address of the burst
  logic [BL_BYTE_W-1:0] bl_bytes;
  logic                 start;     // Header goes out this cycle
  logic                 pop;       // Response beat this cycle

  assign bl_bytes = BL_BYTE_W'(bl_i) * BL_BYTE_W'(ADDR_STEP);

  assign start = (state_q == IDLE) && mem_req_i && spi_init_done_i &&
                 cmd_fifo_empty_i && !cfg_fsm_reset_i;
  assign pop   = (state_q == READ_DATA) && !res_fifo_empty_i && bry_i;

  // ------------------------------
  // State and countdown
  // ------------------------------
  always_ff @(posedge mclk) begin
    if (!rst_n || cfg_fsm_reset_i) begin
      state_q  <= IDLE;
      bl_cnt_q <= '0;
    end else begin
      state_q  <= state_d;
      bl_cnt_q <= bl_cnt_d;
    end
  end

  // Address word follows the header, so take it now
  always_ff @(posedge mclk) begin
    if (start) begin
      addr_q <= adr_i;
    end
  end

  always_comb begin
    state_d          = state_q;
    bl_cnt_d         = bl_cnt_q;
    cmd_fifo_wr_o    = 1'b0;
    cmd_fifo_wdata_o = '0;
    res_fifo_rd_o    = 1'b0;
    mem_ack_o        = 1'b0;
    mem_last_o       = 1'b0;
    mem_rdata_o      = '0;
    unique case (state_q)
      IDLE: begin
        if (start) begin
          cmd_fifo_wr_o    = 1'b1;
          cmd_fifo_wdata_o = {SOC, NOC, bl_bytes,
                              cfg_i.dummy_cnt, cfg_i.addr_cnt,
                              cfg_i.switch_pt, cfg_i.fmode, cfg_i.imode,
                              cfg_i.seq, cfg_i.cs,
                              cfg_i.mode_byte, cfg_i.cmd_byte};
          bl_cnt_d         = bl_i;
          state_d          = ADDR_PHASE;
        end
      end
      ADDR_PHASE: begin
        cmd_fifo_wr_o    = 1'b1;
        cmd_fifo_wdata_o = {NOC, EOC, 16'h0, addr_q};  // Read ends the command
        state_d          = CMD_WAIT;
      end
      CMD_WAIT: begin
        if (cmd_fifo_empty_i) begin  // Engine took both words
          state_d = READ_DATA;
        end
      end
      READ_DATA: begin
        if (pop) begin
          res_fifo_rd_o = 1'b1;
          mem_ack_o     = 1'b1;
          mem_rdata_o   = res_fifo_rdata_i;
          bl_cnt_d      = bl_cnt_q - 1'b1;
          if (bl_cnt_q <= burst_len_t'(1)) begin  // Final beat, zero length too
            mem_last_o = 1'b1;
            bl_cnt_d   = '0;
            state_d    = IDLE;
          end
        end
      end
    endcase
  end

  // ------------------------------
  // Checks
  // ------------------------------
  a_no_late_cmd: assert property (@(posedge mclk) disable iff (!rst_n)
    (state_q inside {CMD_WAIT, READ_DATA}) |-> !cmd_fifo_wr_o);

  a_no_rd_empty: assert property (@(posedge mclk) disable iff (!rst_n)
    res_fifo_rd_o |-> !res_fifo_empty_i);

endmodule

`default_nettype wire

/* hw/qspim_cs_decode.sv */
`default_nettype none

module qspim_cs_decode (
  input  qspim_pkg::wb_data_t   adr_i,
  // Chip select map
  input  qspim_pkg::cs_field_t  cfg_cs0_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs1_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs2_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs3_addr_i,
  input  qspim_pkg::cs_field_t  cfg_cs0_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs1_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs2_amask_i,
  input  qspim_pkg::cs_field_t  cfg_cs3_amask_i,
  // Group 0, CS0 and CS1
  input  qspim_pkg::spi_mode_t  cfg_g0_imode_i,
  input  qspim_pkg::spi_mode_t  cfg_g0_fmode_i,
  input  qspim_pkg::spi_mode_t  cfg_g0_switch_i,
  input  qspim_pkg::spi_seq_t   cfg_g0_seq_i,
  input  qspim_pkg::addr_cnt_t  cfg_g0_addr_cnt_i,
  input  qspim_pkg::dummy_cnt_t cfg_g0_dummy_cnt_i,
  input  qspim_pkg::spi_byte_t  cfg_g0_cmd_i,
  input  qspim_pkg::spi_byte_t  cfg_g0_mode_i,
  // Group 1, CS2 and CS3
  input  qspim_pkg::spi_mode_t  cfg_g1_imode_i,
  input  qspim_pkg::spi_mode_t  cfg_g1_fmode_i,
  input  qspim_pkg::spi_mode_t  cfg_g1_switch_i,
  input  qspim_pkg::spi_seq_t   cfg_g1_seq_i,
  input  qspim_pkg::addr_cnt_t  cfg_g1_addr_cnt_i,
  input  qspim_pkg::dummy_cnt_t cfg_g1_dummy_cnt_i,
  input  qspim_pkg::spi_byte_t  cfg_g1_cmd_i,
  input  qspim_pkg::spi_byte_t  cfg_g1_mode_i,
  qspim_cmd_cfg_if.src          cfg_o
);
  import qspim_pkg::*;

  cs_field_t cs_adr;    // Address bits 27:20
  cs_vec_t   cs_vec;
  logic      grp1_sel;  // CS2 or CS3 hit

  assign cs_adr = adr_i[CS_ADDR_MSB:CS_ADDR_LSB];

  // ------------------------------
  // Masked compare per chip select
  // ------------------------------
  assign cs_vec[0] = ((cs_adr & cfg_cs0_amask_i) == cfg_cs0_addr_i);
  assign cs_vec[1] = ((cs_adr & cfg_cs1_amask_i) == cfg_cs1_addr_i);
  assign cs_vec[2] = ((cs_adr & cfg_cs2_amask_i) == cfg_cs2_addr_i);
  assign cs_vec[3] = ((cs_adr & cfg_cs3_amask_i) == cfg_cs3_addr_i);

  // No hit or a low chip select falls back to group 0
  assign grp1_sel = (cs_vec == 4'b0100) || (cs_vec == 4'b1000);

  assign cfg_o.cs        = cs_vec;
  assign cfg_o.imode     = grp1_sel ? cfg_g1_imode_i     : cfg_g0_imode_i;
  assign cfg_o.fmode     = grp1_sel ? cfg_g1_fmode_i     : cfg_g0_fmode_i;
  assign cfg_o.switch_pt = grp1_sel ? cfg_g1_switch_i    : cfg_g0_switch_i;
  assign cfg_o.seq       = grp1_sel ? cfg_g1_seq_i       : cfg_g0_seq_i;
  assign cfg_o.addr_cnt  = grp1_sel ? cfg_g1_addr_cnt_i  : cfg_g0_addr_cnt_i;
  assign cfg_o.dummy_cnt = grp1_sel ? cfg_g1_dummy_cnt_i : cfg_g0_dummy_cnt_i;
  assign cfg_o.cmd_byte  = grp1_sel ? cfg_g1_cmd_i       : cfg_g0_cmd_i;
  assign cfg_o.mode_byte = grp1_sel ? cfg_g1_mode_i      : cfg_g0_mode_i;

  // Overlapping windows would put two CS lines in one header
  always_comb begin
    if (!adr_i[REGION_BIT]) begin
      a_cs_onehot: assert #0 ($onehot0(cs_vec));
    end
  end

endmodule

`default_nettype wire

/* hw/qspim_cmd_cfg_if.sv */
`default_nettype none

// Settings of the chip select hit by the current address
interface qspim_cmd_cfg_if;
  import qspim_pkg::*;

  cs_vec_t    cs;         // One-hot chip select
  spi_mode_t  imode;      // Initial lane mode
  spi_mode_t  fmode;      // Final lane mode
  spi_mode_t  switch_pt;  // Where the mode switches
  spi_seq_t   seq;        // Phase sequence
  addr_cnt_t  addr_cnt;
  dummy_cnt_t dummy_cnt;
  spi_byte_t  cmd_byte;   // Opcode
  spi_byte_t  mode_byte;

  // Decoder side, combinational from the bus address
  modport src (
    output cs, imode, fmode, switch_pt, seq,
    output addr_cnt, dummy_cnt, cmd_byte, mode_byte
  );

  // Sequencer side, sampled on header write
  modport dst (
    input cs, imode, fmode, switch_pt, seq,
    input addr_cnt, dummy_cnt, cmd_byte, mode_byte
  );

endinterface

`default_nettype wire

/* hw/qspim_pkg.sv */
`default_nettype none

package qspim_pkg;

  // ------------------------------
  // Address map
  // ------------------------------
  localparam int REGION_BIT  = 28;  // High selects the register region
  localparam int CS_ADDR_MSB = 27;  // Chip select compare field
  localparam int CS_ADDR_LSB = 20;
  localparam int REG_IDX_MSB = 5;   // Register index in the word address
  localparam int REG_IDX_LSB = 2;
  localparam int ADDR_STEP   = 4;   // Bytes per beat

  // ------------------------------
  // Command word
  // ------------------------------
  localparam int CMD_WORD_W = 50;
  localparam int BL_BYTE_W  = 12;   // Burst length field, in bytes
  localparam logic SOC = 1'b1;      // Start of command
  localparam logic EOC = 1'b1;      // End of command
  localparam logic NOC = 1'b0;      // Flag not set

  // Bus side
  typedef logic [31:0] wb_data_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [3:0]  byte_en_t;
  typedef logic [9:0]  burst_len_t;  // Words

  // Chip select map
  typedef logic [3:0]  cs_vec_t;     // One-hot
  typedef logic [7:0]  cs_field_t;

  // SPI command settings
  typedef logic [1:0]  spi_mode_t;
  typedef logic [3:0]  spi_seq_t;
  typedef logic [1:0]  addr_cnt_t;
  typedef logic [3:0]  dummy_cnt_t;
  typedef logic [7:0]  spi_byte_t;

  typedef logic [CMD_WORD_W-1:0] cmd_word_t;

  // Memory read sequencer
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    ADDR_PHASE = 2'd1,
    CMD_WAIT   = 2'd2,
    READ_DATA  = 2'd3
  } mem_rd_state_e;

endpackage

`default_nettype wire
